// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  byte_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_and,
        alu_or,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_exec,
        st_mem,
        st_wb,
        st_out,
        st_in
    } core_state_t;

    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_out    = 7'b0001011; // custom-0
    localparam logic [6:0] op_in     = 7'b0101011; // custom-1

    localparam int ram_words  = 64;
    localparam int ram_addr_w = $clog2(ram_words);

    localparam reg_idx_t test_reg = 5'd10; // Register shown on the debug port

    // Both UART directions use the same bit time in clocks
    localparam int clks_per_bit = 8;
    localparam int bit_timer_w  = $clog2(clks_per_bit);
    typedef logic [bit_timer_w-1:0] bit_timer_t;
    localparam bit_timer_t bit_last = bit_timer_t'(clks_per_bit - 1);
    localparam bit_timer_t bit_mid  = bit_timer_t'(clks_per_bit / 2 - 1);

endpackage

`default_nettype wire

// File: src/ctrl_if.sv
`default_nettype none

interface ctrl_if;
    import core_pkg::*;

    word_t    imm;
    alu_op_t  alu_op;
    logic     alu_src;   // Second ALU operand is the immediate
    reg_idx_t rs1, rs2, rd;
    logic     reg_write, mem_read, mem_write;
    logic     branch_eq, branch_ne, jump;
    logic     data_out, data_in;

    modport dec (output imm, alu_op, alu_src, rs1, rs2, rd, reg_write, mem_read,
                 mem_write, branch_eq, branch_ne, jump, data_out, data_in);
    modport ex (input imm, alu_op, alu_src, branch_eq, branch_ne, jump);
    modport rf (input rs1, rs2, rd);

endinterface

`default_nettype wire

// File: src/instr_mem.sv
`default_nettype none

module instr_mem (
    input  logic            clk,
    input  logic            en,
    input  core_pkg::word_t addr,
    output core_pkg::word_t instr
);
    import core_pkg::*;

    // The boot program reads four bytes, echoes each as (b ^ 8'h55) + 1 and sums them in x10
    always_ff @(posedge clk) begin
        if (en) begin
            case (addr[31:2])
                30'd0:   instr <= 32'h00400293; // addi x5, x0, 4
                30'd1:   instr <= 32'h05500313; // addi x6, x0, 0x55
                30'd2:   instr <= 32'h0ff00593; // addi x11, x0, 255
                30'd3:   instr <= 32'h000003ab; // in   x7
                30'd4:   instr <= 32'h00750533; // add  x10, x10, x7
                30'd5:   instr <= 32'h0063c433; // xor  x8, x7, x6
                30'd6:   instr <= 32'h00802023; // sw   x8, 0(x0)
                30'd7:   instr <= 32'h00002483; // lw   x9, 0(x0)
                30'd8:   instr <= 32'h00148493; // addi x9, x9, 1
                30'd9:   instr <= 32'h00b4f4b3; // and  x9, x9, x11
                30'd10:  instr <= 32'h0004800b; // out  x9
                30'd11:  instr <= 32'hfff28293; // addi x5, x5, -1
                30'd12:  instr <= 32'hfc029ee3; // bne  x5, x0, -36
                30'd13:  instr <= 32'h0000006f; // jal  x0, 0
                default: instr <= 32'h00000013; // NOP
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/decode.sv
`default_nettype none

module decode (
    input  logic            clk,
    input  logic            rst,
    input  logic            en,
    input  core_pkg::word_t instr,
    ctrl_if.dec             ctrl
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_next;
    alu_op_t    arith, alu_next;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        case (opcode)
            op_store:  imm_next = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch: imm_next = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            op_jal:    imm_next = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:   imm_next = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // Register and immediate forms share funct3 but only op_reg has SUB
    always_comb begin
        case (funct3)
            3'b010:  arith = alu_slt;
            3'b100:  arith = alu_xor;
            3'b110:  arith = alu_or;
            3'b111:  arith = alu_and;
            default: arith = (opcode == op_reg && instr[30]) ? alu_sub : alu_add;
        endcase
        case (opcode)
            op_imm, op_reg: alu_next = arith;
            op_branch:      alu_next = alu_sub;
            op_jal, op_out: alu_next = alu_pass_b;
            default:        alu_next = alu_add; // Load and store address
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {ctrl.reg_write, ctrl.mem_read, ctrl.mem_write, ctrl.jump} <= '0;
            {ctrl.branch_eq, ctrl.branch_ne, ctrl.data_out, ctrl.data_in} <= '0;
            ctrl.alu_op  <= alu_add;
            ctrl.alu_src <= 1'b0;
        end else if (en) begin
            ctrl.reg_write <= opcode inside {op_imm, op_reg, op_load, op_jal, op_in};
            ctrl.mem_read  <= opcode == op_load;
            ctrl.mem_write <= opcode == op_store;
            ctrl.jump      <= opcode == op_jal;
            ctrl.branch_eq <= opcode == op_branch && funct3 == 3'b000;
            ctrl.branch_ne <= opcode == op_branch && funct3 == 3'b001;
            ctrl.data_out  <= opcode == op_out;
            ctrl.data_in   <= opcode == op_in;
            ctrl.alu_src   <= opcode inside {op_imm, op_load, op_store, op_jal};
            ctrl.alu_op    <= alu_next;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            ctrl.imm <= imm_next;
            ctrl.rs1 <= instr[19:15];
            ctrl.rs2 <= instr[24:20];
            ctrl.rd  <= instr[11:7];
        end
    end

endmodule

`default_nettype wire

// File: src/exec.sv
`default_nettype none

module exec (
    input  core_pkg::word_t pc,
    ctrl_if.ex              ctrl,
    input  core_pkg::word_t rs1_data,
    input  core_pkg::word_t rs2_data,
    output core_pkg::word_t alu_result,
    output core_pkg::word_t store_data,
    output logic            branch_taken,
    output core_pkg::word_t branch_target
);
    import core_pkg::*;

    word_t op_b;
    logic  equal;

    assign op_b = ctrl.alu_src ? ctrl.imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            alu_add: alu_result = rs1_data + op_b;
            alu_sub: alu_result = rs1_data - op_b;
            alu_xor: alu_result = rs1_data ^ op_b;
            alu_and: alu_result = rs1_data & op_b;
            alu_or:  alu_result = rs1_data | op_b;
            alu_slt: alu_result = {31'b0, $signed(rs1_data) < $signed(op_b)};
            default: alu_result = op_b;
        endcase
    end

    // BEQ and BNE both compare the two register operands
    assign equal = rs1_data == rs2_data;
    assign branch_taken = ctrl.jump | (ctrl.branch_eq & equal) | (ctrl.branch_ne & ~equal);
    assign branch_target = pc + ctrl.imm; // Same adder serves JAL and the branches
    assign store_data = rs2_data;

endmodule

`default_nettype wire

// File: src/register_file.sv
`default_nettype none

module register_file (
    input  logic            clk,
    input  logic            rst,
    ctrl_if.rf              ctrl,
    input  logic            we,
    input  core_pkg::word_t wb_data,
    output core_pkg::word_t rs1_data,
    output core_pkg::word_t rs2_data,
    output core_pkg::word_t test
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && ctrl.rd != '0) begin // x0 keeps its reset value of zero
            regs[ctrl.rd] <= wb_data;
        end
    end

    assign rs1_data = regs[ctrl.rs1];
    assign rs2_data = regs[ctrl.rs2];
    assign test     = regs[test_reg];

endmodule

`default_nettype wire

// File: src/data_ram.sv
`default_nettype none

module data_ram (
    input  logic                            clk,
    input  logic                            en,
    input  logic                            we,
    input  logic [core_pkg::ram_addr_w-1:0] addr,
    input  core_pkg::word_t                 wdata,
    output core_pkg::word_t                 rdata
);
    import core_pkg::*;

    word_t mem [ram_words];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr]; // Old contents on a write cycle
        end
    end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`default_nettype none

module uart_tx (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  core_pkg::byte_t data,
    output logic            busy,
    output logic            line
);
    import core_pkg::*;

    logic [9:0] shift;   // Stop bit, data, start bit
    logic [3:0] bit_cnt;
    bit_timer_t timer;

    always_ff @(posedge clk) begin
        if (rst) begin
            shift   <= '1;
            busy    <= 1'b0;
            bit_cnt <= '0;
            timer   <= '0;
        end else if (!busy) begin
            if (start) begin
                shift   <= {1'b1, data, 1'b0};
                busy    <= 1'b1;
                bit_cnt <= '0;
                timer   <= '0;
            end
        end else begin
            timer <= timer + 1'b1;
            if (timer == bit_last) begin
                timer   <= '0;
                shift   <= {1'b1, shift[9:1]}; // Ones fill in behind so the line idles high
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    assign line = shift[0];

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`default_nettype none

module uart_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic            line,
    input  logic            take,
    output logic            ready,
    output core_pkg::byte_t data
);
    import core_pkg::*;

    logic       line_meta, line_sync;
    logic       active;
    logic [3:0] bit_cnt;
    bit_timer_t timer;
    byte_t      shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_meta <= 1'b1;
            line_sync <= 1'b1;
            active    <= 1'b0;
            ready     <= 1'b0;
            bit_cnt   <= '0;
            timer     <= '0;
        end else begin
            line_meta <= line;
            line_sync <= line_meta;
            if (take) begin
                ready <= 1'b0;
            end
            if (!active) begin
                if (!line_sync) begin // Falling edge of a start bit
                    active  <= 1'b1;
                    bit_cnt <= '0;
                    timer   <= '0;
                end
            end else begin
                timer <= timer + 1'b1;
                if (bit_cnt == 4'd0) begin
                    // Recheck the start bit at mid-bit, then sample once per bit time
                    if (timer == bit_mid) begin
                        timer   <= '0;
                        active  <= !line_sync;
                        bit_cnt <= 4'd1;
                    end
                end else if (timer == bit_last) begin
                    timer   <= '0;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 4'd9) begin
                        active <= 1'b0;
                        if (line_sync) begin // A low stop bit drops the byte
                            ready <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active && bit_cnt != 4'd0 && timer == bit_last) begin
            if (bit_cnt == 4'd9) begin
                data <= shift;
            end else begin
                shift <= {line_sync, shift[7:1]}; // LSB arrives first
            end
        end
    end

endmodule

`default_nettype wire

// File: src/core.sv
`default_nettype none

module core (
    input  logic            clk,
    input  logic            rst,
    input  logic            uart_rx_line,
    output logic            uart_tx_line,
    output core_pkg::word_t test
);
    import core_pkg::*;

    core_state_t state;
    word_t       pc, pc_plus4, instr;
    word_t       rs1_data, rs2_data, alu_result, store_data, branch_target;
    word_t       ram_rdata, wb_data;
    word_t       mem_result_q, wb_q;
    logic        branch_taken, rf_we;
    logic        tx_start, tx_busy, rx_take, rx_ready;
    byte_t       rx_data;

    ctrl_if ctrl ();

    instr_mem instr_mem_inst (.clk, .en(state == st_fetch), .addr(pc), .instr);

    decode decode_inst (.clk, .rst, .en(state == st_decode), .instr, .ctrl(ctrl.dec));

    exec exec_inst (
        .pc, .ctrl(ctrl.ex), .rs1_data, .rs2_data,
        .alu_result, .store_data, .branch_taken, .branch_target
    );

    register_file register_file_inst (
        .clk, .rst, .ctrl(ctrl.rf), .we(rf_we), .wb_data, .rs1_data, .rs2_data, .test
    );

    data_ram data_ram_inst (
        .clk, .en(state == st_mem), .we(ctrl.mem_write),
        .addr(mem_result_q[ram_addr_w+1:2]), .wdata(store_data), .rdata(ram_rdata)
    );

    uart_tx uart_tx_inst (
        .clk, .rst, .start(tx_start), .data(rs1_data[7:0]), .busy(tx_busy), .line(uart_tx_line)
    );

    uart_rx uart_rx_inst (
        .clk, .rst, .line(uart_rx_line), .take(rx_take), .ready(rx_ready), .data(rx_data)
    );

    assign pc_plus4 = pc + 32'd4;
    assign tx_start = state == st_out && !tx_busy;
    assign rx_take  = state == st_in && rx_ready;
    assign rf_we    = state == st_wb && ctrl.reg_write;
    assign wb_data  = ctrl.mem_read ? ram_rdata : wb_q; // RAM data arrives in st_wb

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch;
            pc    <= '0;
        end else begin
            case (state)
                st_fetch:  state <= st_decode;
                st_decode: state <= st_exec;
                st_exec:   state <= ctrl.data_out ? st_out : ctrl.data_in ? st_in : st_mem;
                st_out:    if (!tx_busy) state <= st_mem;
                st_in:     if (rx_ready) state <= st_mem;
                st_mem:    state <= st_wb;
                st_wb: begin
                    state <= st_fetch;
                    pc    <= branch_taken ? branch_target : pc_plus4;
                end
                default:   state <= st_fetch;
            endcase
        end
    end

    // Memory-stage result and write-back value
    always_ff @(posedge clk) begin
        if (state == st_exec) begin
            mem_result_q <= alu_result;
        end
        if (rx_take) begin
            wb_q <= {24'h0, rx_data};
        end else if (state == st_mem && !ctrl.data_in) begin
            wb_q <= ctrl.jump ? pc_plus4 : mem_result_q; // JAL links pc + 4
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 20; // 40 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: sim/core_tb.sv
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    localparam int num_bytes   = 4;
    localparam int reset_cycles = 10;
    localparam int idle_cycles = 300;
    localparam int halt_cycles = 400;
    // About twice the reset, idle, echo and halt phases put together
    localparam int timeout_cycles = 4000;
    localparam logic [31:0] lfsr_seed = 32'h5f1f675b;

    logic        clk;
    logic        rst;
    logic        uart_rx_line;
    logic        uart_tx_line;
    word_t       test;
    int          errors = 0;
    int          cycles = 0;
    int          frames_seen = 0;
    byte_t       last_rx;
    logic [31:0] lfsr = lfsr_seed;

    tb_clock tb_clock_inst (.clk);

    core core_inst (.clk, .rst, .uart_rx_line, .uart_tx_line, .test);

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("Error: %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0}; // Start bit goes out first
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            uart_rx_line = frame[i];
            repeat (clks_per_bit - 1) @(negedge clk);
        end
    endtask

    // Frame starts are seen half a clock late, so mid-bit is a few falling edges further on
    initial begin : tx_monitor
        byte_t b;
        b = '0;
        forever begin
            @(negedge clk);
            if (!rst && !uart_tx_line) begin
                repeat (clks_per_bit / 2 - 1) @(negedge clk);
                check_value("uart_tx_line start bit", 32'h0, word_t'(uart_tx_line));
                for (int i = 0; i < 8; i++) begin
                    repeat (clks_per_bit) @(negedge clk);
                    b = {uart_tx_line, b[7:1]};
                end
                repeat (clks_per_bit) @(negedge clk);
                check_value("uart_tx_line stop bit", 32'h1, word_t'(uart_tx_line));
                last_rx = b;
                frames_seen++;
            end
        end
    end

    initial begin : watchdog
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: no result after %0d cycles, errors so far: %0d", cycles, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        byte_t b;
        byte_t echo_exp;
        word_t sum;
        rst = 1'b1;
        uart_rx_line = 1'b1;
        sum = '0;
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clk);
            check_value("uart_tx_line", 32'h1, word_t'(uart_tx_line));
            check_value("test", 32'h0, test);
        end
        rst = 1'b0;
        @(negedge clk);
        check_value("uart_tx_line", 32'h1, word_t'(uart_tx_line));
        check_value("test", 32'h0, test);

        // The program sits in IN until a byte arrives
        for (int i = 0; i < idle_cycles; i++) begin
            @(negedge clk);
            check_value("uart_tx_line", 32'h1, word_t'(uart_tx_line));
        end

        for (int i = 0; i < num_bytes; i++) begin
            random_byte(b);
            sum = sum + word_t'(b);
            echo_exp = (b ^ 8'h55) + 8'd1;
            send_byte(b);
            while (frames_seen <= i) begin
                @(negedge clk);
            end
            check_value("uart_tx_line echo byte", word_t'(echo_exp), word_t'(last_rx));
        end
        check_value("test", sum, test); // x10 holds the byte sum

        random_byte(b);
        send_byte(b);
        repeat (halt_cycles) @(negedge clk);
        assert (frames_seen == num_bytes) else begin
            $display("A byte was transmitted after the program should have halted");
            errors++;
        end

        $display("Errors: %0d after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: core.f
src/core_pkg.sv
src/ctrl_if.sv
src/instr_mem.sv
src/decode.sv
src/exec.sv
src/register_file.sv
src/data_ram.sv
src/uart_tx.sv
src/uart_rx.sv
src/core.sv
sim/tb_clock.sv
sim/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
